// File: hw/core_isa_pkg.sv
package core_isa_pkg;

	// ======================================================================
	// Machine widths
	// ======================================================================

	// Data and address width
	localparam int XLEN = 32;
	// Architectural integer registers
	localparam int NUM_REGS = 32;

	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

	// Fixed 32-bit encoding, no compressed words
	localparam logic [XLEN-1:0] INSTR_ADVANCE = 32'd4;

	// ======================================================================
	// Instruction word fields
	// ======================================================================

	// Low bit of each register and funct field
	localparam int RD_LSB = 7;
	localparam int F3_LSB = 12;
	localparam int RS1_LSB = 15;
	localparam int RS2_LSB = 20;
	localparam int F7_LSB = 25;

	// Major opcodes of the kept subset
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

	// funct3 for OP and OP-IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// funct3 for MISC-MEM
	localparam logic [2:0] F3_FENCE = 3'b000;
	localparam logic [2:0] F3_FENCE_I = 3'b001;

	// Selects SUB and SRA/SRAI
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

endpackage

// File: hw/core_ctrl_pkg.sv
package core_ctrl_pkg;

	// ======================================================================
	// ALU control
	// ======================================================================

	// Internal op code, independent of the ISA encoding
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_SLL = 4'd2,
		ALU_LT  = 4'd3,
		ALU_LTU = 4'd4,
		ALU_XOR = 4'd5,
		ALU_SRL = 4'd6,
		ALU_SRA = 4'd7,
		ALU_OR  = 4'd8,
		ALU_AND = 4'd9
	} alu_op_t;

	// ======================================================================
	// Operand selects
	// ======================================================================

	// Operand A: forwarded rs1, PC for AUIPC, zero for LUI
	typedef enum logic [1:0] {
		SRCA_RS1  = 2'd0,
		SRCA_PC   = 2'd1,
		SRCA_ZERO = 2'd2
	} src_a_t;

	// Operand B: forwarded rs2 or immediate
	typedef enum logic {
		SRCB_RS2 = 1'b0,
		SRCB_IMM = 1'b1
	} src_b_t;

	// Shift amount, low bits of operand B
	localparam int SHAMT_W = 5;

endpackage

// File: hw/dec_if.sv
interface dec_if;

	// Stage valid, low for bubbles
	logic                          valid;
	core_ctrl_pkg::alu_op_t        alu_op;
	core_ctrl_pkg::src_a_t         src_a;
	core_ctrl_pkg::src_b_t         src_b;
	// Selected immediate, I or U format
	logic [core_isa_pkg::XLEN-1:0] imm;
	logic [core_isa_pkg::XLEN-1:0] pc;
	// Source indices for forwarding compares
	core_isa_pkg::reg_idx_t        rs1;
	core_isa_pkg::reg_idx_t        rs2;
	// Zero for no-ops and illegal words
	core_isa_pkg::reg_idx_t        rd;
	logic                          illegal;

	modport dec (
		output valid, alu_op, src_a, src_b, imm, pc, rs1, rs2, rd, illegal
	);

	modport exe (
		input valid, alu_op, src_a, src_b, imm, pc, rs1, rs2, rd, illegal
	);

endinterface

// File: hw/instr_decoder.sv
module instr_decoder #(
	parameter logic [core_isa_pkg::XLEN-1:0] RESET_VECTOR = '0
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          instr_valid_i,
	input  logic [core_isa_pkg::XLEN-1:0] instr_i,
	dec_if.dec                            dec_o
);

	localparam int IDX_W = $bits(core_isa_pkg::reg_idx_t);

	// Instruction fields
	logic [6:0]             opcode;
	logic [2:0]             funct3;
	logic [6:0]             funct7;
	core_isa_pkg::reg_idx_t f_rd;
	core_isa_pkg::reg_idx_t f_rs1;
	core_isa_pkg::reg_idx_t f_rs2;

	logic [core_isa_pkg::XLEN-1:0] imm_i;
	logic [core_isa_pkg::XLEN-1:0] imm_u;

	// Decoded controls, before the D-to-X register
	core_ctrl_pkg::alu_op_t        d_alu_op;
	core_ctrl_pkg::src_a_t         d_src_a;
	core_ctrl_pkg::src_b_t         d_src_b;
	logic [core_isa_pkg::XLEN-1:0] d_imm;
	core_isa_pkg::reg_idx_t        d_rd;
	logic                          d_illegal;

	// Fetch address of the word at the input
	logic [core_isa_pkg::XLEN-1:0] pc_q;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[core_isa_pkg::F3_LSB +: 3];
	assign funct7 = instr_i[core_isa_pkg::F7_LSB +: 7];
	assign f_rd = instr_i[core_isa_pkg::RD_LSB +: IDX_W];
	assign f_rs1 = instr_i[core_isa_pkg::RS1_LSB +: IDX_W];
	assign f_rs2 = instr_i[core_isa_pkg::RS2_LSB +: IDX_W];

	// Sign-extended I format, upper-aligned U format
	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_u = {instr_i[31:12], 12'b0};

	// funct3 to ALU op, alt picks SUB or SRA
	function automatic core_ctrl_pkg::alu_op_t alu_op_for(logic [2:0] f3, logic alt);
		case (f3)
			core_isa_pkg::F3_ADD_SUB: return alt ? core_ctrl_pkg::ALU_SUB : core_ctrl_pkg::ALU_ADD;
			core_isa_pkg::F3_SLL:     return core_ctrl_pkg::ALU_SLL;
			core_isa_pkg::F3_SLT:     return core_ctrl_pkg::ALU_LT;
			core_isa_pkg::F3_SLTU:    return core_ctrl_pkg::ALU_LTU;
			core_isa_pkg::F3_XOR:     return core_ctrl_pkg::ALU_XOR;
			core_isa_pkg::F3_SR:      return alt ? core_ctrl_pkg::ALU_SRA : core_ctrl_pkg::ALU_SRL;
			core_isa_pkg::F3_OR:      return core_ctrl_pkg::ALU_OR;
			default:                  return core_ctrl_pkg::ALU_AND;
		endcase
	endfunction

	// ======================================================================
	// Decode
	// ======================================================================

	always_comb begin
		// Defaults are those of a register-register op
		d_alu_op = core_ctrl_pkg::ALU_ADD;
		d_src_a = core_ctrl_pkg::SRCA_RS1;
		d_src_b = core_ctrl_pkg::SRCB_RS2;
		d_imm = imm_i;
		d_rd = f_rd;
		d_illegal = 1'b0;

		case (opcode)
			core_isa_pkg::OPC_OP_IMM: begin
				d_src_b = core_ctrl_pkg::SRCB_IMM;
				// funct7 only meaningful for the shifts
				d_alu_op = alu_op_for(funct3,
					(funct3 == core_isa_pkg::F3_SR) && (funct7 == core_isa_pkg::FUNCT7_ALT));
				if (funct3 == core_isa_pkg::F3_SLL && funct7 != 7'b0)
					d_illegal = 1'b1;
				if (funct3 == core_isa_pkg::F3_SR && funct7 != 7'b0 &&
						funct7 != core_isa_pkg::FUNCT7_ALT)
					d_illegal = 1'b1;
			end
			core_isa_pkg::OPC_OP: begin
				d_alu_op = alu_op_for(funct3, funct7 == core_isa_pkg::FUNCT7_ALT);
				// Alt encoding exists for ADD/SUB and SRL/SRA only
				if (funct7 == core_isa_pkg::FUNCT7_ALT) begin
					if (funct3 != core_isa_pkg::F3_ADD_SUB && funct3 != core_isa_pkg::F3_SR)
						d_illegal = 1'b1;
				end else if (funct7 != 7'b0) begin
					d_illegal = 1'b1;
				end
			end
			core_isa_pkg::OPC_LUI: begin
				d_src_a = core_ctrl_pkg::SRCA_ZERO;
				d_src_b = core_ctrl_pkg::SRCB_IMM;
				d_imm = imm_u;
			end
			core_isa_pkg::OPC_AUIPC: begin
				d_src_a = core_ctrl_pkg::SRCA_PC;
				d_src_b = core_ctrl_pkg::SRCB_IMM;
				d_imm = imm_u;
			end
			core_isa_pkg::OPC_MISC_MEM: begin
				// FENCE and FENCE.I have nothing to order here
				d_rd = '0;
				if (funct3 != core_isa_pkg::F3_FENCE && funct3 != core_isa_pkg::F3_FENCE_I)
					d_illegal = 1'b1;
			end
			default: begin
				d_illegal = 1'b1;
			end
		endcase

		// Illegal words retire without a write
		if (d_illegal)
			d_rd = '0;
	end

	// ======================================================================
	// D-to-X register and PC
	// ======================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_o.valid <= 1'b0;
			pc_q <= RESET_VECTOR;
		end else begin
			dec_o.valid <= instr_valid_i;
			// Bubbles hold the PC
			if (instr_valid_i)
				pc_q <= pc_q + core_isa_pkg::INSTR_ADVANCE;
		end
	end

	// Payload follows the input every edge, qualified by valid
	always_ff @(posedge clk) begin
		dec_o.alu_op <= d_alu_op;
		dec_o.src_a <= d_src_a;
		dec_o.src_b <= d_src_b;
		dec_o.imm <= d_imm;
		dec_o.pc <= pc_q;
		dec_o.rs1 <= f_rs1;
		dec_o.rs2 <= f_rs2;
		dec_o.rd <= d_rd;
		dec_o.illegal <= d_illegal;
	end

endmodule

// File: hw/reg_file.sv
module reg_file (
	input  logic                          clk,
	input  logic                          rst_n,
	input  core_isa_pkg::reg_idx_t        rd_addr_a_i,
	input  core_isa_pkg::reg_idx_t        rd_addr_b_i,
	output logic [core_isa_pkg::XLEN-1:0] rd_data_a_o,
	output logic [core_isa_pkg::XLEN-1:0] rd_data_b_o,
	input  logic                          wr_en_i,
	input  core_isa_pkg::reg_idx_t        wr_addr_i,
	input  logic [core_isa_pkg::XLEN-1:0] wr_data_i
);

	// x0 has no storage
	logic [core_isa_pkg::XLEN-1:0] regs [1:core_isa_pkg::NUM_REGS-1];

	// Write-first read, covers a producer three words back
	function automatic logic [core_isa_pkg::XLEN-1:0] read_port(core_isa_pkg::reg_idx_t addr);
		if (addr == '0)
			return '0;
		else if (wr_en_i && wr_addr_i == addr)
			return wr_data_i;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < core_isa_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en_i && wr_addr_i != '0) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// Read data registered alongside the D-to-X controls
	always_ff @(posedge clk) begin
		rd_data_a_o <= read_port(rd_addr_a_i);
		rd_data_b_o <= read_port(rd_addr_b_i);
	end

endmodule

// File: hw/int_alu.sv
module int_alu (
	input  core_ctrl_pkg::alu_op_t        op_i,
	input  logic [core_isa_pkg::XLEN-1:0] a_i,
	input  logic [core_isa_pkg::XLEN-1:0] b_i,
	output logic [core_isa_pkg::XLEN-1:0] result_o
);

	localparam int XLEN = core_isa_pkg::XLEN;

	logic [core_ctrl_pkg::SHAMT_W-1:0] shamt;
	logic                              lt_signed;
	logic                              lt_unsigned;

	// Shifts use only the low bits of B
	assign shamt = b_i[core_ctrl_pkg::SHAMT_W-1:0];
	assign lt_signed = $signed(a_i) < $signed(b_i);
	assign lt_unsigned = a_i < b_i;

	always_comb begin
		case (op_i)
			core_ctrl_pkg::ALU_ADD: result_o = a_i + b_i;
			core_ctrl_pkg::ALU_SUB: result_o = a_i - b_i;
			core_ctrl_pkg::ALU_SLL: result_o = a_i << shamt;
			// Set-less-than yields 0 or 1
			core_ctrl_pkg::ALU_LT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
			core_ctrl_pkg::ALU_LTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
			core_ctrl_pkg::ALU_XOR: result_o = a_i ^ b_i;
			core_ctrl_pkg::ALU_SRL: result_o = a_i >> shamt;
			// Arithmetic shift keeps the sign
			core_ctrl_pkg::ALU_SRA: result_o = $unsigned($signed(a_i) >>> shamt);
			core_ctrl_pkg::ALU_OR:  result_o = a_i | b_i;
			core_ctrl_pkg::ALU_AND: result_o = a_i & b_i;
			default:                result_o = '0;
		endcase
	end

endmodule

// File: hw/exec_unit.sv
module exec_unit (
	input  logic                          clk,
	input  logic                          rst_n,
	dec_if.exe                            dec_i,
	input  logic [core_isa_pkg::XLEN-1:0] rs1_data_i,
	input  logic [core_isa_pkg::XLEN-1:0] rs2_data_i,
	output logic                          wr_en_o,
	output core_isa_pkg::reg_idx_t        wr_addr_o,
	output logic [core_isa_pkg::XLEN-1:0] wr_data_o,
	output logic                          retire_valid_o,
	output logic [core_isa_pkg::XLEN-1:0] retire_pc_o,
	output core_isa_pkg::reg_idx_t        retire_rd_o,
	output logic [core_isa_pkg::XLEN-1:0] retire_data_o,
	output logic                          retire_illegal_o
);

	// X-to-M register
	logic                          xm_valid;
	logic [core_isa_pkg::XLEN-1:0] xm_pc;
	core_isa_pkg::reg_idx_t        xm_rd;
	logic [core_isa_pkg::XLEN-1:0] xm_result;
	logic                          xm_illegal;

	// M-to-W register
	logic                          mw_valid;
	logic [core_isa_pkg::XLEN-1:0] mw_pc;
	core_isa_pkg::reg_idx_t        mw_rd;
	logic [core_isa_pkg::XLEN-1:0] mw_result;
	logic                          mw_illegal;

	logic [core_isa_pkg::XLEN-1:0] fwd_rs1;
	logic [core_isa_pkg::XLEN-1:0] fwd_rs2;
	logic [core_isa_pkg::XLEN-1:0] op_a;
	logic [core_isa_pkg::XLEN-1:0] op_b;
	logic [core_isa_pkg::XLEN-1:0] x_result;

	// Youngest producer wins, register file data otherwise
	function automatic logic [core_isa_pkg::XLEN-1:0] forward(
		core_isa_pkg::reg_idx_t        idx,
		logic [core_isa_pkg::XLEN-1:0] rf_data
	);
		if (xm_valid && xm_rd != '0 && xm_rd == idx)
			return xm_result;
		else if (mw_valid && mw_rd != '0 && mw_rd == idx)
			return mw_result;
		else
			return rf_data;
	endfunction

	// ======================================================================
	// Stage X
	// ======================================================================

	always_comb begin
		fwd_rs1 = forward(dec_i.rs1, rs1_data_i);
		fwd_rs2 = forward(dec_i.rs2, rs2_data_i);

		case (dec_i.src_a)
			core_ctrl_pkg::SRCA_RS1: op_a = fwd_rs1;
			core_ctrl_pkg::SRCA_PC:  op_a = dec_i.pc;
			default:                 op_a = '0;
		endcase

		op_b = (dec_i.src_b == core_ctrl_pkg::SRCB_IMM) ? dec_i.imm : fwd_rs2;
	end

	int_alu i_alu (
		.op_i     (dec_i.alu_op),
		.a_i      (op_a),
		.b_i      (op_b),
		.result_o (x_result)
	);

	// ======================================================================
	// Stages M and W
	// ======================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xm_valid <= 1'b0;
			mw_valid <= 1'b0;
		end else begin
			xm_valid <= dec_i.valid;
			mw_valid <= xm_valid;
		end
	end

	// Payload moves every edge, bubbles carry stale data
	always_ff @(posedge clk) begin
		xm_pc <= dec_i.pc;
		xm_rd <= dec_i.rd;
		xm_result <= x_result;
		xm_illegal <= dec_i.illegal;
		mw_pc <= xm_pc;
		mw_rd <= xm_rd;
		mw_result <= xm_result;
		mw_illegal <= xm_illegal;
	end

	// Write port, x0 never written
	assign wr_en_o = mw_valid && (mw_rd != '0);
	assign wr_addr_o = mw_rd;
	assign wr_data_o = mw_result;

	// Retire view of the same register
	assign retire_valid_o = mw_valid;
	assign retire_pc_o = mw_pc;
	assign retire_rd_o = mw_rd;
	assign retire_data_o = mw_result;
	assign retire_illegal_o = mw_illegal;

endmodule

// File: hw/int_core.sv
module int_core #(
	parameter logic [core_isa_pkg::XLEN-1:0] RESET_VECTOR = '0
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          instr_valid_i,
	input  logic [core_isa_pkg::XLEN-1:0] instr_i,
	output logic                          retire_valid_o,
	output logic [core_isa_pkg::XLEN-1:0] retire_pc_o,
	output core_isa_pkg::reg_idx_t        retire_rd_o,
	output logic [core_isa_pkg::XLEN-1:0] retire_data_o,
	output logic                          retire_illegal_o
);

	localparam int IDX_W = $bits(core_isa_pkg::reg_idx_t);

	// Register file read data, aligned with the D-to-X register
	logic [core_isa_pkg::XLEN-1:0] rs1_data;
	logic [core_isa_pkg::XLEN-1:0] rs2_data;

	// Write-back from stage W
	logic                          wr_en;
	core_isa_pkg::reg_idx_t        wr_addr;
	logic [core_isa_pkg::XLEN-1:0] wr_data;

	dec_if dec_bus ();

	instr_decoder #(
		.RESET_VECTOR (RESET_VECTOR)
	) i_decoder (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.dec_o         (dec_bus)
	);

	// Source fields go straight to the read ports
	reg_file i_reg_file (
		.clk         (clk),
		.rst_n       (rst_n),
		.rd_addr_a_i (instr_i[core_isa_pkg::RS1_LSB +: IDX_W]),
		.rd_addr_b_i (instr_i[core_isa_pkg::RS2_LSB +: IDX_W]),
		.rd_data_a_o (rs1_data),
		.rd_data_b_o (rs2_data),
		.wr_en_i     (wr_en),
		.wr_addr_i   (wr_addr),
		.wr_data_i   (wr_data)
	);

	exec_unit i_exec (
		.clk              (clk),
		.rst_n            (rst_n),
		.dec_i            (dec_bus),
		.rs1_data_i       (rs1_data),
		.rs2_data_i       (rs2_data),
		.wr_en_o          (wr_en),
		.wr_addr_o        (wr_addr),
		.wr_data_o        (wr_data),
		.retire_valid_o   (retire_valid_o),
		.retire_pc_o      (retire_pc_o),
		.retire_rd_o      (retire_rd_o),
		.retire_data_o    (retire_data_o),
		.retire_illegal_o (retire_illegal_o)
	);

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 10;

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Released on a rising edge, like the other inputs
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// File: testbench/tb_int_core.sv
module tb_int_core;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] RESET_VECTOR = 32'h0000_1000;
	// Retire seen three edges after the accept edge
	localparam int RETIRE_EDGES = 3;
	localparam int RESET_TIMEOUT = 50;
	localparam int DRAIN_TIMEOUT = 20;

	// RV32I major opcodes
	localparam logic [6:0] OP = 7'b0110011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] LUI = 7'b0110111;
	localparam logic [6:0] AUIPC = 7'b0010111;
	localparam logic [6:0] MISC_MEM = 7'b0001111;

	// One expected retire tagged with its accept edge
	typedef struct packed {
		int          tag;
		logic [31:0] pc;
		logic [4:0]  rd;
		logic [31:0] data;
		logic        illegal;
	} retire_t;

	logic        clk;
	logic        rst_n;
	logic        instr_valid_i;
	logic [31:0] instr_i;
	logic        retire_valid_o;
	logic [31:0] retire_pc_o;
	logic [4:0]  retire_rd_o;
	logic [31:0] retire_data_o;
	logic        retire_illegal_o;

	// Reference architectural state
	logic [31:0] model_regs [0:31] = '{default: '0};
	logic [31:0] model_pc = RESET_VECTOR;
	retire_t     exp_q [$];
	int          cycle = 0;
	int          retired_count = 0;
	logic        head_present = 1'b0;
	retire_t     head = '0;

	tb_clock_gen i_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	int_core #(
		.RESET_VECTOR (RESET_VECTOR)
	) i_dut (
		.clk              (clk),
		.rst_n            (rst_n),
		.instr_valid_i    (instr_valid_i),
		.instr_i          (instr_i),
		.retire_valid_o   (retire_valid_o),
		.retire_pc_o      (retire_pc_o),
		.retire_rd_o      (retire_rd_o),
		.retire_data_o    (retire_data_o),
		.retire_illegal_o (retire_illegal_o)
	);

	// ======================================================================
	// Failure reporting
	// ======================================================================

	task automatic stop_with_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_problem(input string reason);
		$display("Error: %s", reason);
		stop_with_failure();
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("** Error [%s] expected 0x%08h actual 0x%08h", name, expected, actual);
		stop_with_failure();
	endtask

	// ======================================================================
	// Reference model
	// ======================================================================

	function automatic retire_t model_step(input logic [31:0] word);
		retire_t     e;
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic        legal;
		opc = word[6:0];
		f3 = word[14:12];
		f7 = word[31:25];
		a = model_regs[word[19:15]];
		// Operand B is the I immediate for OP-IMM and rs2 for OP
		b = (opc == OP_IMM) ? {{20{word[31]}}, word[31:20]} : model_regs[word[24:20]];
		legal = 1'b1;
		res = '0;
		case (opc)
			OP_IMM, OP: begin
				case (f3)
					3'b000: res = (opc == OP && f7[5]) ? a - b : a + b;
					3'b001: res = a << b[4:0];
					// Sign bits decide when they differ
					3'b010: res = ((a[31] != b[31]) ? a[31] : (a < b)) ? 32'd1 : 32'd0;
					3'b011: res = (a < b) ? 32'd1 : 32'd0;
					3'b100: res = a ^ b;
					3'b101: begin
						// Vacated upper bits take the sign for SRA
						if (f7[5])
							res = (a >> b[4:0]) |
								(~(32'hffff_ffff >> b[4:0]) & {32{a[31]}});
						else
							res = a >> b[4:0];
					end
					3'b110: res = a | b;
					default: res = a & b;
				endcase
				// Only SUB and SRA/SRAI have an alternate funct7
				if (opc == OP)
					legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
				else if (f3 == 3'b001)
					legal = (f7 == 7'h00);
				else if (f3 == 3'b101)
					legal = (f7 == 7'h00) || (f7 == 7'h20);
			end
			LUI: res = {word[31:12], 12'h000};
			AUIPC: res = model_pc + {word[31:12], 12'h000};
			MISC_MEM: legal = (f3 == 3'b000) || (f3 == 3'b001);
			default: legal = 1'b0;
		endcase
		e.tag = cycle;
		e.pc = model_pc;
		e.rd = (legal && opc != MISC_MEM) ? word[11:7] : 5'd0;
		e.data = res;
		e.illegal = !legal;
		if (e.rd != 5'd0)
			model_regs[e.rd] = res;
		model_pc = model_pc + 32'd4;
		return e;
	endfunction

	// Retire pops before the word accepted on this edge is pushed
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (rst_n && retire_valid_o && exp_q.size() != 0) begin
			void'(exp_q.pop_front());
			retired_count <= retired_count + 1;
		end
		if (rst_n && instr_valid_i)
			exp_q.push_back(model_step(instr_i));
		head_present <= (exp_q.size() != 0);
		if (exp_q.size() != 0)
			head <= exp_q[0];
	end

	// ======================================================================
	// Checks
	// ======================================================================

	reset_quiet: assert property (@(posedge clk) !rst_n |-> !retire_valid_o)
		else report_problem("retire_valid_o went high during reset");
	retire_expected: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid_o |-> head_present)
		else report_problem("a word retired while none was pending");
	retire_latency: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid_o && head_present |-> cycle - head.tag == RETIRE_EDGES)
		else report_mismatch("retire latency", RETIRE_EDGES,
			$sampled(cycle) - $sampled(head.tag));
	retire_overdue: assert property (@(posedge clk) disable iff (!rst_n)
		head_present && cycle - head.tag >= RETIRE_EDGES |-> retire_valid_o)
		else report_problem("an accepted word did not retire in time");
	first_pc: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid_o && retired_count == 0 |-> retire_pc_o == RESET_VECTOR)
		else report_mismatch("first retire pc", RESET_VECTOR, $sampled(retire_pc_o));
	pc_match: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid_o && head_present |-> retire_pc_o == head.pc)
		else report_mismatch("retire pc", $sampled(head.pc), $sampled(retire_pc_o));
	rd_match: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid_o && head_present |-> retire_rd_o == head.rd)
		else report_mismatch("retire rd", 32'($sampled(head.rd)), 32'($sampled(retire_rd_o)));
	illegal_match: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid_o && head_present |-> retire_illegal_o == head.illegal)
		else report_mismatch("retire illegal", 32'($sampled(head.illegal)),
			32'($sampled(retire_illegal_o)));
	// Result only matters where it is written
	data_match: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid_o && head_present && head.rd != 5'd0 |-> retire_data_o == head.data)
		else report_mismatch("retire data", $sampled(head.data), $sampled(retire_data_o));

	// ======================================================================
	// Stimulus
	// ======================================================================

	function automatic logic [31:0] encode_itype(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] encode_rtype(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
			input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] encode_utype(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	// Indices x0 to x7 keep dependencies close together
	function automatic logic [4:0] pick_reg();
		return 5'($urandom_range(7, 0));
	endfunction

	task automatic issue(input logic [31:0] word);
		@(posedge clk);
		instr_valid_i <= 1'b1;
		instr_i <= word;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			instr_valid_i <= 1'b0;
			// Junk on the bus during bubbles
			instr_i <= $urandom();
		end
	endtask

	task automatic issue_gapped(input logic [31:0] word);
		if ($urandom_range(3, 0) == 0)
			idle($urandom_range(3, 1));
		issue(word);
	endtask

	task automatic seed_regs();
		for (int r = 1; r < 8; r++) begin
			issue(encode_utype(20'($urandom()), 5'(r), LUI));
			issue(encode_itype(12'($urandom()), 5'(r), 3'b000, 5'(r), OP_IMM));
		end
	endtask

	task automatic run_imm_ops(input int count);
		logic [2:0]  f3;
		logic [11:0] imm;
		for (int i = 0; i < count; i++) begin
			f3 = 3'($urandom_range(7, 0));
			imm = 12'($urandom());
			// Shifts keep funct7 in the upper immediate bits
			if (f3 == 3'b001)
				imm[11:5] = 7'h00;
			else if (f3 == 3'b101)
				imm[11:5] = ($urandom_range(1, 0) == 1) ? 7'h20 : 7'h00;
			issue_gapped(encode_itype(imm, pick_reg(), f3, pick_reg(), OP_IMM));
		end
	endtask

	task automatic run_reg_ops(input int count, input logic gaps);
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] word;
		for (int i = 0; i < count; i++) begin
			f3 = 3'($urandom_range(7, 0));
			f7 = 7'h00;
			if ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(1, 0) == 1)
				f7 = 7'h20;
			word = encode_rtype(f7, pick_reg(), pick_reg(), f3, pick_reg(), OP);
			if (gaps)
				issue_gapped(word);
			else
				issue(word);
		end
	endtask

	task automatic run_upper_ops(input int count);
		for (int i = 0; i < count; i++)
			issue_gapped(encode_utype(20'($urandom()), pick_reg(),
				($urandom_range(1, 0) == 1) ? LUI : AUIPC));
	endtask

	task automatic run_directed_imm();
		// Negative source for SRAI
		issue(encode_utype(20'h80000, 5'd5, LUI));
		issue(encode_itype({7'h20, 5'd7}, 5'd5, 3'b101, 5'd6, OP_IMM));
		// SLTIU and SLTI against sign-extended immediates
		issue(encode_itype(12'hfff, 5'd6, 3'b011, 5'd7, OP_IMM));
		issue(encode_itype(12'h800, 5'd6, 3'b010, 5'd4, OP_IMM));
	endtask

	task automatic run_forwarding_chain();
		// x1 consumed at distance 1, 2, 3 and 4
		issue(encode_itype(12'h5a3, 5'd0, 3'b000, 5'd1, OP_IMM));
		issue(encode_rtype(7'h00, 5'd1, 5'd1, 3'b000, 5'd2, OP));
		issue(encode_rtype(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, OP));
		issue(encode_rtype(7'h00, 5'd3, 5'd1, 3'b110, 5'd4, OP));
		issue(encode_rtype(7'h00, 5'd2, 5'd1, 3'b111, 5'd5, OP));
		// Younger of two pending x6 producers wins
		issue(encode_itype(12'h001, 5'd0, 3'b000, 5'd6, OP_IMM));
		issue(encode_itype(12'h002, 5'd0, 3'b000, 5'd6, OP_IMM));
		issue(encode_rtype(7'h00, 5'd6, 5'd6, 3'b000, 5'd7, OP));
	endtask

	task automatic run_noop_cases();
		// Dropped write to x0 followed by reads of x0
		issue(encode_itype(12'h04d, 5'd1, 3'b000, 5'd0, OP_IMM));
		issue(encode_rtype(7'h00, 5'd0, 5'd0, 3'b000, 5'd1, OP));
		issue(encode_itype(12'h001, 5'd0, 3'b110, 5'd2, OP_IMM));
		// FENCE and FENCE.I carrying non-zero rd fields
		issue(encode_itype(12'h0ff, 5'd0, 3'b000, 5'd2, MISC_MEM));
		issue(encode_itype(12'h000, 5'd0, 3'b001, 5'd3, MISC_MEM));
		// Unknown words mostly carry a non-zero rd field
		issue(32'h0000_0000);
		issue(32'hffff_ffff);
		issue(encode_itype(12'h000, 5'd3, 3'b010, 5'd3, 7'b0000011));
		issue(encode_rtype(7'h01, 5'd2, 5'd1, 3'b000, 5'd4, OP));
		issue(encode_itype(12'h401, 5'd5, 3'b001, 5'd5, OP_IMM));
		issue(encode_itype(12'h000, 5'd0, 3'b010, 5'd6, MISC_MEM));
		// Read every register back through its own ADD with x0
		for (int r = 1; r < 8; r++)
			issue(encode_rtype(7'h00, 5'd0, 5'(r), 3'b000, 5'(r), OP));
	endtask

	initial begin
		instr_valid_i = 1'b0;
		instr_i = '0;
		void'($urandom(15));

		for (int i = 0; i < RESET_TIMEOUT && !rst_n; i++)
			@(posedge clk);
		if (!rst_n)
			report_problem("reset was never released");

		// Nothing may retire before the first accepted word
		idle(5);
		issue(encode_utype(20'h00000, 5'd1, AUIPC));
		seed_regs();
		run_directed_imm();
		run_imm_ops(60);
		run_forwarding_chain();
		run_reg_ops(60, 1'b0);
		run_reg_ops(40, 1'b1);
		run_upper_ops(20);
		run_noop_cases();
		repeat (4) begin
			run_imm_ops(10);
			run_reg_ops(10, 1'b1);
			run_upper_ops(4);
		end
		idle(RETIRE_EDGES + 1);

		for (int i = 0; i < DRAIN_TIMEOUT && head_present; i++)
			@(posedge clk);
		idle(2);
		if (head_present) begin
			report_problem("accepted words still pending after the drain timeout");
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

// File: int_core.f
hw/core_isa_pkg.sv
hw/core_ctrl_pkg.sv
hw/dec_if.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/int_alu.sv
hw/exec_unit.sv
hw/int_core.sv
testbench/tb_clock_gen.sv
testbench/tb_int_core.sv

// File: run.sh
#!/bin/sh
# Compile the int_core testbench with Verilator, run it, search for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_int_core -Mdir obj_dir -f int_core.f &&
./obj_dir/Vtb_int_core | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
